// ==== logic/sa_pkg.sv ====
`default_nettype none

// shared sizes and row types for the result-unloading path
package sa_pkg;

    // one mac lane per output word
    localparam int lanes = 8;

    // signed operand width
    localparam int act_w = 8;

    // accumulator width, also the egress word width
    localparam int lane_w = 64;

    // full result row
    localparam int row_w = lanes * lane_w;

    // default number of rows the buffer can hold
    localparam int def_depth = 4;

    // eight operands per beat
    // lane i sits at bits 8i and up
    // elements read unsigned, so lanes apply $signed themselves
    typedef logic [lanes-1:0][act_w-1:0] opvec_t;

    // one finished row, lane i at bits 64i and up
    typedef logic [lanes-1:0][lane_w-1:0] row_t;

    // one egress word
    typedef logic [lane_w-1:0] word_t;

endpackage

`default_nettype wire

// ==== logic/mac_row_array.sv ====
`timescale 1ns/1ns
`default_nettype none

// eight signed mac lanes
// each accepted beat adds act*wgt per lane
// the last beat of a tile moves the sums into a holding row
module mac_row_array #(
    parameter int DEPTH = sa_pkg::def_depth
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  logic           in_last,
    input  sa_pkg::opvec_t in_act,
    input  sa_pkg::opvec_t in_wgt,
    output logic           in_ready,
    output logic           push,
    output sa_pkg::row_t   push_data,
    input  logic           credit
);

    import sa_pkg::*;

    localparam int cnt_w = $clog2(DEPTH + 1);

    // running sums, one per lane
    logic signed [lane_w-1:0]  acc_q [lanes];
    // this beat's products and the sums they give
    logic signed [2*act_w-1:0] prod [lanes];
    logic signed [lane_w-1:0]  sum [lanes];

    // finished row waiting for a credit
    row_t             hold_q;
    logic             hold_valid_q;

    // free slots in the row buffer
    logic [cnt_w-1:0] credit_cnt_q;

    logic             accept;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            prod[i] = $signed(in_act[i]) * $signed(in_wgt[i]);
            // sign extend the 16-bit product to accumulator width
            sum[i] = acc_q[i] + {{(lane_w - 2*act_w){prod[i][2*act_w-1]}}, prod[i]};
        end
    end

    // push needs a held row and at least one free slot
    assign push      = hold_valid_q && (credit_cnt_q != '0);
    assign push_data = hold_q;

    // stall the source only while a finished row is stuck
    assign in_ready  = !hold_valid_q || push;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q        <= '{default: '0};
            hold_valid_q <= 1'b0;
            credit_cnt_q <= cnt_w'(DEPTH);
        end else begin
            if (accept) begin
                for (int i = 0; i < lanes; i++) begin
                    // clear on tile end, next tile starts at zero
                    acc_q[i] <= in_last ? '0 : sum[i];
                end
            end

            if (accept && in_last) begin
                hold_valid_q <= 1'b1;
            end else if (push) begin
                hold_valid_q <= 1'b0;
            end

            // push and return in the same cycle cancel out
            case ({push, credit})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    // completed sums, captured with the last beat
    always_ff @(posedge clk) begin
        if (accept && in_last) begin
            for (int i = 0; i < lanes; i++) begin
                hold_q[i] <= sum[i];
            end
        end
    end

    // buffer must never hand back more slots than it has
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_cnt_q <= cnt_w'(DEPTH));

endmodule

`default_nettype wire

// ==== logic/row_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// show-ahead circular buffer
// oldest entry always visible at head
// every pop returns one credit on the next cycle
module row_fifo #(
    parameter int  DEPTH  = sa_pkg::def_depth,
    parameter type data_t = logic
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  data_t push_data,
    input  logic  pop,
    output data_t head,
    output logic  empty,
    output logic  credit
);

    // one-entry buffer still needs a pointer bit
    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    data_t            mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             credit_q;
    logic             full;

    assign empty  = (count_q == '0);
    assign full   = (count_q == cnt_w'(DEPTH));
    assign head   = mem[rd_ptr_q];
    assign credit = credit_q;

    // storage, written at the edge so head shows it next cycle
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            // pointers wrap by compare, depth need not be a power of two
            if (push) begin
                if (wr_ptr_q == ptr_w'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end

            if (pop) begin
                if (rd_ptr_q == ptr_w'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end

            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // one credit per entry freed
            credit_q <= pop;
        end
    end

    // producer credit count should keep this from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== logic/output_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

// row serializer
// pulls one row from the buffer, sends it as eight words, lane 0 first
module output_datapath (
    input  logic          clk,
    input  logic          reset,
    input  logic          empty,
    input  sa_pkg::row_t  head,
    output logic          pop,
    output logic          out_valid,
    output sa_pkg::word_t out_data,
    input  logic          out_ready,
    output logic          row_done
);

    import sa_pkg::*;

    localparam int cnt_w = $clog2(lanes);

    // load register doubles as the shift register
    logic [row_w-1:0] shift_q;
    // words already sent from this row
    logic [cnt_w-1:0] cnt_q;
    // a row is loaded and being sent
    logic             busy_q;

    logic             xfer;
    logic             last_word;

    // grab the next row only when idle
    assign pop       = !busy_q && !empty;

    assign out_valid = busy_q;
    // low word is always the next lane out
    assign out_data  = shift_q[lane_w-1:0];

    assign xfer      = out_valid && out_ready;
    assign last_word = (cnt_q == cnt_w'(lanes - 1));

    // terminal count on a transfer marks end of row
    assign row_done  = xfer && last_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (pop) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (xfer) begin
                // wraps back to zero after the eighth word
                cnt_q <= cnt_q + 1'b1;
                if (last_word) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= head;
        end else if (xfer) begin
            // drop the sent lane, next one moves down
            shift_q <= shift_q >> lane_w;
        end
    end

    // word must hold while the sink stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== logic/systolic_out_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// mac row -> credit buffer -> word serializer
module systolic_out_top #(
    parameter int DEPTH = sa_pkg::def_depth
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  logic           in_last,
    input  sa_pkg::opvec_t in_act,
    input  sa_pkg::opvec_t in_wgt,
    output logic           in_ready,
    output logic           out_valid,
    output sa_pkg::word_t  out_data,
    input  logic           out_ready,
    output logic           row_done
);

    import sa_pkg::*;

    // producer to buffer
    logic push;
    row_t push_data;
    // buffer back to producer
    logic credit;
    // buffer to consumer
    logic pop;
    logic empty;
    row_t head;

    mac_row_array #(
        .DEPTH(DEPTH)
    ) u_producer (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_act    (in_act),
        .in_wgt    (in_wgt),
        .in_ready  (in_ready),
        .push      (push),
        .push_data (push_data),
        .credit    (credit)
    );

    // same depth on both ends keeps the credit loop exact
    row_fifo #(
        .DEPTH  (DEPTH),
        .data_t (row_t)
    ) u_buffer (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .credit    (credit)
    );

    output_datapath u_consumer (
        .clk       (clk),
        .reset     (reset),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .row_done  (row_done)
    );

endmodule

`default_nettype wire

// ==== verif/tb_systolic_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_systolic_out;

    import sa_pkg::*;

    localparam int depth      = def_depth;
    localparam int wait_limit = 500;
    localparam int max_beats  = 8;

    logic   clk;
    logic   reset;
    logic   in_valid;
    logic   in_last;
    opvec_t in_act;
    opvec_t in_wgt;
    logic   in_ready;
    logic   out_valid;
    word_t  out_data;
    logic   out_ready;
    logic   row_done;

    // separate streams so operand and stall patterns do not interleave
    integer seed       = 32'h2ed46e81;
    integer ready_seed = 32'h2ed46e81;

    // 0 always ready, 1 random stalls, 2 held low
    int     ready_mode = 0;
    int     err_count = 0;
    int     check_count = 0;
    int     done_count = 0;
    int     test_count = 0;
    int     test_ok = 0;
    bit     timed_out = 1'b0;

    // current tile operands, one entry per beat
    opvec_t tile_act [max_beats];
    opvec_t tile_wgt [max_beats];

    // expected words in egress order
    word_t  exp_q [$];

    // monitor state
    int     word_idx = 0;
    bit     stall_pending = 1'b0;
    word_t  held_data;
    word_t  mon_word;

    systolic_out_top #(
        .DEPTH(depth)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_act    (in_act),
        .in_wgt    (in_wgt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .row_done  (row_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // sink side, updated 10 ns after each rising edge
    always @(posedge clk) begin
        #10;
        case (ready_mode)
            0:       out_ready = 1'b1;
            // roughly 40 percent low
            1:       out_ready = ($unsigned($random(ready_seed)) % 10) >= 4;
            default: out_ready = 1'b0;
        endcase
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // expected lane sums, signed act*wgt summed over the beats of the tile
    function automatic row_t ref_row(input int n);
        row_t   r;
        longint s;
        for (int i = 0; i < lanes; i++) begin
            s = 0;
            for (int b = 0; b < n; b++) begin
                s += longint'($signed(tile_act[b][i])) * longint'($signed(tile_wgt[b][i]));
            end
            r[i] = s;
        end
        return r;
    endfunction

    // mixed signs plus the most negative corner on lane 0
    task automatic fill_known_tile();
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < lanes; i++) begin
                tile_act[b][i] = 8'(i - 4 + b);
                tile_wgt[b][i] = 8'(2 * b - i);
            end
        end
        tile_act[2][0] = 8'h80;
        tile_wgt[2][0] = 8'h80;
    endtask

    task automatic fill_random_tile(input int n);
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < lanes; i++) begin
                tile_act[b][i] = 8'($random(seed));
                tile_wgt[b][i] = 8'($random(seed));
            end
        end
    endtask

    // in_ready depends only on state, so mid-cycle tells the next edge
    task automatic wait_in_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready && !timed_out) begin
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout: operand input never became ready at %0t", $time);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic send_tile(input int n);
        row_t r;
        r = ref_row(n);
        for (int i = 0; i < lanes; i++) begin
            exp_q.push_back(r[i]);
        end
        for (int b = 0; b < n && !timed_out; b++) begin
            in_valid = 1'b1;
            in_act   = tile_act[b];
            in_wgt   = tile_wgt[b];
            in_last  = (b == n - 1);
            wait_in_ready();
            if (!timed_out) begin
                // beat is taken on this edge
                @(posedge clk);
                #10;
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || out_valid) && !timed_out) begin
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout: %0d output words never arrived", exp_q.size());
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic send_random_tiles(input int count);
        int n;
        // first beat goes out just after a rising edge
        @(posedge clk);
        #10;
        for (int t = 0; t < count && !timed_out; t++) begin
            n = 1 + int'($unsigned($random(seed)) % 6);
            fill_random_tile(n);
            send_tile(n);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before && !timed_out) begin
            test_ok++;
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: errors", test_count, name);
        end
    endtask

    // output side, sampled mid-cycle while everything is settled
    always @(negedge clk) begin
        if (reset) begin
            word_idx      = 0;
            stall_pending = 1'b0;
        end else begin
            if (stall_pending && out_valid) begin
                check_value(out_data, held_data, "out_data held during stall");
            end
            stall_pending = out_valid && !out_ready;
            held_data     = out_data;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("output word %h arrived when none was expected", out_data);
                end else begin
                    mon_word = exp_q.pop_front();
                    check_value(out_data, mon_word, "output word");
                end
                // row_done only with the eighth word of a row
                check_value(64'(row_done), 64'(word_idx == lanes - 1), "row_done");
                word_idx = (word_idx + 1) % lanes;
            end
            if (row_done) begin
                done_count++;
            end
        end
    end

    initial begin
        int errs;
        int done_before;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_act   = '0;
        in_wgt   = '0;
        out_ready = 1'b0;

        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        // idle state straight after reset
        errs = err_count;
        @(negedge clk);
        check_value(64'(out_valid), 64'd0, "out_valid after reset");
        check_value(64'(row_done), 64'd0, "row_done after reset");
        check_value(64'(in_ready), 64'd1, "in_ready after reset");
        @(posedge clk);
        #10;
        report_test("reset state", errs);

        if (!timed_out) begin
            errs = err_count;
            done_before = done_count;
            fill_known_tile();
            send_tile(3);
            wait_drain();
            check_value(64'(done_count - done_before), 64'd1, "row_done count");
            report_test("single tile", errs);
        end

        if (!timed_out) begin
            errs = err_count;
            done_before = done_count;
            send_random_tiles(12);
            wait_drain();
            check_value(64'(done_count - done_before), 64'd12, "row_done count");
            report_test("back-to-back tiles", errs);
        end

        if (!timed_out) begin
            errs = err_count;
            done_before = done_count;
            ready_mode = 1;
            send_random_tiles(12);
            wait_drain();
            ready_mode = 0;
            check_value(64'(done_count - done_before), 64'd12, "row_done count");
            report_test("egress stalls", errs);
        end

        if (!timed_out) begin
            int cycles;
            errs = err_count;
            done_before = done_count;
            ready_mode = 2;
            // buffer, shift register and producer hold fill up exactly
            send_random_tiles(depth + 2);
            cycles = 0;
            @(negedge clk);
            while (in_ready && cycles < wait_limit) begin
                cycles++;
                @(negedge clk);
            end
            check_value(64'(in_ready), 64'd0, "in_ready under back-pressure");
            ready_mode = 0;
            wait_drain();
            check_value(64'(done_count - done_before), 64'(depth + 2), "row_done count");
            report_test("credit back-pressure", errs);
        end

        $display("tests %0d, ok %0d, checks %0d, errors %0d",
                 test_count, test_ok, check_count, err_count);
        if (timed_out || err_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/sa_pkg.sv
logic/mac_row_array.sv
logic/row_fifo.sv
logic/output_datapath.sv
logic/systolic_out_top.sv
verif/tb_systolic_out.sv

// ==== Makefile ====
TOP = tb_systolic_out

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f
	verilator --lint-only --top-module systolic_out_top logic/sa_pkg.sv \
		logic/mac_row_array.sv logic/row_fifo.sv logic/output_datapath.sv \
		logic/systolic_out_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Test completed successfully" sim.log || \
		{ echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log
